// ==== src/fetch_pkg.sv ====
////////////////////
// fetch package
// widths, superscalar fetch width and branch target
// buffer geometry shared by the fetch front end
////////////////////

package fetch_pkg;

  ////////////////////
  // datapath widths
  ////////////////////

  // instruction address
  typedef logic [63:0] addr_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  // aligned block returned by instruction memory
  typedef logic [63:0] fetch_block_t;

  // two instructions per fetch
  localparam int NUM_SUPER = 2;

  // one bit per fetch slot
  typedef logic [NUM_SUPER-1:0] slot_mask_t;

  ////////////////////
  // btb geometry
  ////////////////////

  // 16 entries, index from pc bits 5..2
  localparam int BTB_INDEX_BITS = 4;
  typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;

  // everything above the index bits
  localparam int BTB_TAG_BITS = 58;
  typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

  // two bit saturating counter
  typedef logic [1:0] counter_t;

  // install value, also the taken threshold
  localparam counter_t CTR_WEAK_TAKEN = 2'd2;

endpackage

// ==== src/btb_table.sv ====
////////////////////
// btb table
// direct mapped branch target buffer, two combinational
// lookup ports and one training port with 2-bit counters
////////////////////

`timescale 1ns/10ps

module btb_table (
  input  logic                  clock,
  input  logic                  reset,
  // lookup ports
  input  fetch_pkg::btb_index_t lookup_index_0,
  input  fetch_pkg::btb_index_t lookup_index_1,
  input  fetch_pkg::btb_tag_t   lookup_tag_0,
  input  fetch_pkg::btb_tag_t   lookup_tag_1,
  // training port
  input  logic                  write_enable,
  input  fetch_pkg::addr_t      write_pc,
  input  logic                  write_taken,
  input  fetch_pkg::addr_t      write_target,
  // lookup results
  output logic                  hit_0,
  output logic                  hit_1,
  output fetch_pkg::counter_t   counter_0,
  output fetch_pkg::counter_t   counter_1,
  output fetch_pkg::addr_t      target_0,
  output fetch_pkg::addr_t      target_1
);

  import fetch_pkg::*;

  // per-entry state
  logic [2**BTB_INDEX_BITS-1:0] entry_valid;
  btb_tag_t                     entry_tag    [2**BTB_INDEX_BITS];
  addr_t                        entry_target [2**BTB_INDEX_BITS];
  counter_t                     entry_ctr    [2**BTB_INDEX_BITS];

  // training address split
  btb_index_t write_index;
  btb_tag_t   write_tag;
  logic       write_hit;
  counter_t   ctr_up;
  counter_t   ctr_down;

  ////////////////////
  // lookup
  ////////////////////

  // tag compare on both ports in the same cycle
  assign hit_0     = entry_valid[lookup_index_0] && (entry_tag[lookup_index_0] == lookup_tag_0);
  assign hit_1     = entry_valid[lookup_index_1] && (entry_tag[lookup_index_1] == lookup_tag_1);
  assign counter_0 = entry_ctr[lookup_index_0];
  assign counter_1 = entry_ctr[lookup_index_1];
  assign target_0  = entry_target[lookup_index_0];
  assign target_1  = entry_target[lookup_index_1];

  ////////////////////
  // training
  ////////////////////

  // index is pc[5:2], tag is the rest above it
  assign write_index = write_pc[BTB_INDEX_BITS+1:2];
  assign write_tag   = write_pc[$bits(addr_t)-1 -: BTB_TAG_BITS];
  assign write_hit   = entry_valid[write_index] && (entry_tag[write_index] == write_tag);

  // saturating counter steps
  always_comb
  begin
    ctr_up   = entry_ctr[write_index];
    ctr_down = entry_ctr[write_index];
    if (entry_ctr[write_index] != '1)
      ctr_up = entry_ctr[write_index] + counter_t'(1);
    if (entry_ctr[write_index] != '0)
      ctr_down = entry_ctr[write_index] - counter_t'(1);
  end

  // valid bits: only a taken update that misses installs an entry
  always_ff @(posedge clock)
  begin
    if (reset)
      entry_valid <= '0;
    else if (write_enable && write_taken && !write_hit)
      entry_valid[write_index] <= 1'b1;
  end

  // tag, target and counter
  always_ff @(posedge clock)
  begin
    if (write_enable && write_taken)
    begin
      // taken always rewrites the target
      entry_target[write_index] <= write_target;
      if (write_hit)
        entry_ctr[write_index] <= ctr_up;
      else
      begin
        // fresh entry starts weakly taken
        entry_tag[write_index] <= write_tag;
        entry_ctr[write_index] <= CTR_WEAK_TAKEN;
      end
    end
    else if (write_enable && write_hit)
      // not taken on a hit, step down
      entry_ctr[write_index] <= ctr_down;
  end

endmodule

// ==== src/branch_predictor.sv ====
////////////////////
// branch predictor
// looks up both fetch slots in the btb, decides taken
// per slot with slot 0 first, picks the next fetch pc
////////////////////

`timescale 1ns/10ps

module branch_predictor (
  input  logic                  clock,
  input  logic                  reset,
  // from fetch stage
  input  fetch_pkg::addr_t      fetch_pc,
  input  fetch_pkg::addr_t      seq_next_pc,
  input  fetch_pkg::slot_mask_t raw_valid,
  // resolution port from a later stage
  input  logic                  update_valid,
  input  fetch_pkg::addr_t      update_pc,
  input  logic                  update_taken,
  input  fetch_pkg::addr_t      update_target,
  // to fetch stage
  output fetch_pkg::slot_mask_t take_branch,
  output fetch_pkg::addr_t      branch_target,
  output fetch_pkg::addr_t      next_pc,
  output fetch_pkg::slot_mask_t inst_valid
);

  import fetch_pkg::*;

  // slot addresses within the aligned block
  addr_t      slot_pc_0;
  addr_t      slot_pc_1;
  btb_index_t lookup_index_0;
  btb_index_t lookup_index_1;
  btb_tag_t   lookup_tag_0;
  btb_tag_t   lookup_tag_1;

  // table results
  logic       hit_0;
  logic       hit_1;
  counter_t   counter_0;
  counter_t   counter_1;
  addr_t      target_0;
  addr_t      target_1;

  ////////////////////
  // lookup addresses
  ////////////////////

  // slot 0 is the aligned pc, slot 1 the word after it
  assign slot_pc_0 = {fetch_pc[$bits(addr_t)-1:3], 3'b000};
  assign slot_pc_1 = slot_pc_0 + addr_t'(4);

  assign lookup_index_0 = slot_pc_0[BTB_INDEX_BITS+1:2];
  assign lookup_index_1 = slot_pc_1[BTB_INDEX_BITS+1:2];
  assign lookup_tag_0   = slot_pc_0[$bits(addr_t)-1 -: BTB_TAG_BITS];
  assign lookup_tag_1   = slot_pc_1[$bits(addr_t)-1 -: BTB_TAG_BITS];

  btb_table u_btb_table (
    .clock          (clock),
    .reset          (reset),
    .lookup_index_0 (lookup_index_0),
    .lookup_index_1 (lookup_index_1),
    .lookup_tag_0   (lookup_tag_0),
    .lookup_tag_1   (lookup_tag_1),
    .write_enable   (update_valid),
    .write_pc       (update_pc),
    .write_taken    (update_taken),
    .write_target   (update_target),
    .hit_0          (hit_0),
    .hit_1          (hit_1),
    .counter_0      (counter_0),
    .counter_1      (counter_1),
    .target_0       (target_0),
    .target_1       (target_1)
  );

  ////////////////////
  // prediction
  ////////////////////

  // slot 0 wins; slot 1 only counts when slot 0 falls through
  assign take_branch[0] = raw_valid[0] && hit_0 && (counter_0 >= CTR_WEAK_TAKEN);
  assign take_branch[1] = raw_valid[1] && hit_1 && (counter_1 >= CTR_WEAK_TAKEN)
                          && !take_branch[0];

  // target of whichever slot is taken
  always_comb
  begin
    if (take_branch[0])
      branch_target = target_0;
    else
      branch_target = target_1;
  end

  assign next_pc = (|take_branch) ? branch_target : seq_next_pc;

  // instruction behind a taken slot 0 is squashed
  assign inst_valid[0] = raw_valid[0];
  assign inst_valid[1] = raw_valid[1] && !take_branch[0];

endmodule

// ==== src/fetch_stage.sv ====
////////////////////
// fetch stage
// pc register, aligned memory address and split of the
// 64-bit block into two slots with npc and target
////////////////////

`timescale 1ns/10ps

module fetch_stage (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic                                             get_next_inst,
  // instruction memory
  input  fetch_pkg::fetch_block_t                          imem_data,
  input  logic                                             imem_valid,
  // from predictor
  input  fetch_pkg::slot_mask_t                            take_branch,
  input  fetch_pkg::addr_t                                 branch_target,
  input  fetch_pkg::addr_t                                 next_pc,
  input  fetch_pkg::slot_mask_t                            inst_valid,
  // to instruction memory
  output fetch_pkg::addr_t                                 imem_addr,
  // to predictor
  output fetch_pkg::addr_t                                 fetch_pc,
  output fetch_pkg::addr_t                                 seq_next_pc,
  output fetch_pkg::slot_mask_t                            raw_valid,
  // per-slot results down the pipeline
  output fetch_pkg::addr_t     [fetch_pkg::NUM_SUPER-1:0]  npc,
  output fetch_pkg::inst_t     [fetch_pkg::NUM_SUPER-1:0]  ir,
  output fetch_pkg::addr_t     [fetch_pkg::NUM_SUPER-1:0]  target,
  output fetch_pkg::slot_mask_t                            valid_inst
);

  import fetch_pkg::*;

  addr_t pc_q;
  logic  pc_enable;

  ////////////////////
  // pc register
  ////////////////////

  // a predicted branch must not be lost to a stall
  assign pc_enable = (imem_valid && get_next_inst) || (|take_branch);

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_q <= '0;
    else if (pc_enable)
      pc_q <= next_pc;
  end

  assign fetch_pc  = pc_q;

  // memory is read one aligned block at a time
  assign imem_addr = {pc_q[$bits(addr_t)-1:3], 3'b000};

  // upper word only -> step 4, else the whole block
  assign seq_next_pc = pc_q[2] ? (pc_q + addr_t'(4)) : (pc_q + addr_t'(NUM_SUPER * 4));

  // slot 0 holds nothing useful when pc points at the upper word
  assign raw_valid[0] = pc_q[2] ? 1'b0 : imem_valid;
  assign raw_valid[1] = imem_valid;

  ////////////////////
  // slot outputs
  ////////////////////

  always_comb
  begin
    // low half goes to slot 0
    for (int i = 0; i < NUM_SUPER; i++)
      ir[i] = imem_data[i*$bits(inst_t) +: $bits(inst_t)];
  end

  // slot 0 repeats the pc when it sits in the upper word
  assign npc[0] = pc_q[2] ? pc_q : (pc_q + addr_t'(4));
  assign npc[1] = seq_next_pc;

  always_comb
  begin
    // taken slot carries the predicted target
    for (int i = 0; i < NUM_SUPER; i++)
      target[i] = take_branch[i] ? branch_target : npc[i];
  end

  // already masked by the predictor
  assign valid_inst = inst_valid;

endmodule

// ==== src/fetch_unit.sv ====
////////////////////
// fetch unit
// top of the two-wide fetch front end, fetch stage
// plus branch predictor
////////////////////

`timescale 1ns/10ps

module fetch_unit (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic                                            get_next_inst,
  // instruction memory
  input  fetch_pkg::fetch_block_t                         imem_data,
  input  logic                                            imem_valid,
  output fetch_pkg::addr_t                                imem_addr,
  // branch resolution from a later stage
  input  logic                                            update_valid,
  input  fetch_pkg::addr_t                                update_pc,
  input  logic                                            update_taken,
  input  fetch_pkg::addr_t                                update_target,
  // per-slot outputs
  output fetch_pkg::addr_t     [fetch_pkg::NUM_SUPER-1:0] npc,
  output fetch_pkg::inst_t     [fetch_pkg::NUM_SUPER-1:0] ir,
  output fetch_pkg::addr_t     [fetch_pkg::NUM_SUPER-1:0] target,
  output fetch_pkg::slot_mask_t                           inst_valid
);

  import fetch_pkg::*;

  // fetch stage to predictor
  addr_t      fetch_pc;
  addr_t      seq_next_pc;
  slot_mask_t raw_valid;

  // predictor to fetch stage
  slot_mask_t take_branch;
  addr_t      branch_target;
  addr_t      next_pc;
  slot_mask_t pred_inst_valid;

  fetch_stage u_fetch_stage (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .imem_data     (imem_data),
    .imem_valid    (imem_valid),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .next_pc       (next_pc),
    .inst_valid    (pred_inst_valid),
    .imem_addr     (imem_addr),
    .fetch_pc      (fetch_pc),
    .seq_next_pc   (seq_next_pc),
    .raw_valid     (raw_valid),
    .npc           (npc),
    .ir            (ir),
    .target        (target),
    .valid_inst    (inst_valid)
  );

  // trained straight from the resolution port
  branch_predictor u_branch_predictor (
    .clock         (clock),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .seq_next_pc   (seq_next_pc),
    .raw_valid     (raw_valid),
    .update_valid  (update_valid),
    .update_pc     (update_pc),
    .update_taken  (update_taken),
    .update_target (update_target),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .next_pc       (next_pc),
    .inst_valid    (pred_inst_valid)
  );

endmodule

// ==== verif/fetch_unit_asserts.sv ====
////////////////////
// fetch unit checks
// per-cycle rules of the fetch front end,
// bound into the fetch_unit top level
////////////////////

`timescale 1ns/10ps

module fetch_unit_asserts (
  input logic                                            clock,
  input logic                                            reset,
  input logic                                            get_next_inst,
  input fetch_pkg::fetch_block_t                         imem_data,
  input logic                                            imem_valid,
  input fetch_pkg::addr_t                                imem_addr,
  input fetch_pkg::addr_t     [fetch_pkg::NUM_SUPER-1:0] npc,
  input fetch_pkg::inst_t     [fetch_pkg::NUM_SUPER-1:0] ir,
  input fetch_pkg::addr_t     [fetch_pkg::NUM_SUPER-1:0] target,
  input fetch_pkg::slot_mask_t                           inst_valid,
  // internal nets of the top level
  input fetch_pkg::addr_t                                fetch_pc,
  input fetch_pkg::slot_mask_t                           take_branch,
  input fetch_pkg::addr_t                                branch_target
);

  // failures so far, read by the testbench
  int error_count = 0;

  task automatic flag_failure(input string what);
    $error("%s", what);
    error_count++;
  endtask

  ////////////////////
  // combinational rules
  ////////////////////

  ap_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    imem_addr == {fetch_pc[63:3], 3'b000})
    else flag_failure("imem_addr is not the aligned fetch pc");

  // nothing valid without memory data
  ap_no_data: assert property (@(posedge clock) disable iff (reset)
    !imem_valid |-> inst_valid == 2'b00)
    else flag_failure("inst_valid high while imem_valid is low");

  // low half to slot 0
  ap_split: assert property (@(posedge clock) disable iff (reset)
    imem_valid |-> ir[0] == imem_data[31:0] && ir[1] == imem_data[63:32])
    else flag_failure("ir does not match the halves of imem_data");

  ap_npc_low: assert property (@(posedge clock) disable iff (reset)
    !fetch_pc[2] |-> npc[0] == fetch_pc + 64'd4 && npc[1] == fetch_pc + 64'd8)
    else flag_failure("npc wrong for an aligned pc");

  // pc in the upper word: slot 0 repeats the pc and is dropped
  ap_upper_word: assert property (@(posedge clock) disable iff (reset)
    fetch_pc[2] |-> npc[0] == fetch_pc && npc[1] == fetch_pc + 64'd4
                    && !inst_valid[0] && inst_valid[1] == imem_valid)
    else flag_failure("upper word fetch has wrong npc or slot valids");

  ap_no_branch: assert property (@(posedge clock) disable iff (reset)
    !(|take_branch) |-> target[0] == npc[0] && target[1] == npc[1])
    else flag_failure("target differs from npc with no branch predicted");

  // taken slot 0 squashes slot 1
  ap_slot0_taken: assert property (@(posedge clock) disable iff (reset)
    take_branch[0] |-> inst_valid == 2'b01 && target[0] == branch_target)
    else flag_failure("taken slot 0 has wrong valids or target");

  ap_slot1_taken: assert property (@(posedge clock) disable iff (reset)
    take_branch[1] |-> inst_valid[1] && target[1] == branch_target && target[0] == npc[0])
    else flag_failure("taken slot 1 has wrong valid or targets");

  ////////////////////
  // pc update rules
  ////////////////////

  ap_advance: assert property (@(posedge clock) disable iff (reset)
    imem_valid && get_next_inst && !(|take_branch)
    |=> fetch_pc == $past(fetch_pc) + ($past(fetch_pc[2]) ? 64'd4 : 64'd8))
    else flag_failure("pc did not advance sequentially on an accepted fetch");

  ap_hold: assert property (@(posedge clock) disable iff (reset)
    !(imem_valid && get_next_inst) && !(|take_branch) |=> fetch_pc == $past(fetch_pc))
    else flag_failure("pc moved while the fetch was stalled");

  // a prediction redirects even under back-pressure
  ap_redirect: assert property (@(posedge clock) disable iff (reset)
    |take_branch |=> fetch_pc == $past(branch_target))
    else flag_failure("pc did not follow the predicted branch");

endmodule

bind fetch_unit fetch_unit_asserts fetch_checks (.*);

// ==== verif/fetch_unit_tb.sv ====
////////////////////
// fetch unit testbench
// memory model, lfsr driven valid levels, btb training
// and directed pc checks around trained branches
////////////////////

`timescale 1ns/10ps

module fetch_unit_tb;

  import fetch_pkg::*;

  localparam int RESET_CYCLES    = 4;
  localparam int RANDOM_CYCLES   = 24;
  localparam int DIRECTED_CYCLES = 56;
  localparam int STIM_CYCLES     = RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES;
  localparam int WATCHDOG_NS     = 20 * STIM_CYCLES * 10;

  // slot 0 branch into an upper word, slot 1 branch, and a way back
  localparam addr_t BRANCH_A_PC   = 64'h100;
  localparam addr_t BRANCH_A_DEST = 64'h204;
  localparam addr_t BRANCH_B_PC   = 64'h20c;
  localparam addr_t BRANCH_B_DEST = 64'h400;
  localparam addr_t BRANCH_C_PC   = 64'h408;

  logic                   clock;
  logic                   reset;
  logic                   get_next_inst;
  fetch_block_t           imem_data;
  logic                   imem_valid;
  addr_t                  imem_addr;
  logic                   update_valid;
  addr_t                  update_pc;
  logic                   update_taken;
  addr_t                  update_target;
  addr_t [NUM_SUPER-1:0]  npc;
  inst_t [NUM_SUPER-1:0]  ir;
  addr_t [NUM_SUPER-1:0]  target;
  slot_mask_t             inst_valid;

  // pc the fetch unit should hold now
  addr_t       exp_pc;
  logic [31:0] lfsr_state;

  fetch_unit dut (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .imem_data     (imem_data),
    .imem_valid    (imem_valid),
    .imem_addr     (imem_addr),
    .update_valid  (update_valid),
    .update_pc     (update_pc),
    .update_taken  (update_taken),
    .update_target (update_target),
    .npc           (npc),
    .ir            (ir),
    .target        (target),
    .inst_valid    (inst_valid)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // memory model returns the folded address above its complement
  assign imem_data = {imem_addr[63:32] ^ imem_addr[31:0],
                      ~(imem_addr[63:32] ^ imem_addr[31:0])};

  ////////////////////
  // helpers
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic feedback;
    feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], feedback};
  endfunction

  function automatic addr_t block_addr(input addr_t pc);
    return {pc[63:3], 3'b000};
  endfunction

  // upper word steps by one instruction and an aligned pc by a whole block
  function automatic addr_t seq_pc(input addr_t pc);
    return pc + (pc[2] ? 64'd4 : 64'd8);
  endfunction

  task automatic random_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  // high three times out of four
  task automatic random_level(output logic level);
    logic b0;
    logic b1;
    random_bit(b0);
    random_bit(b1);
    level = b0 | b1;
  endtask

  task automatic fail_run(input string reason);
    $display("Simulation failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run("directed check failed");
    end
  endtask

  // drive at edge plus 1 ns and let the outputs settle for 2 ns
  task automatic apply_inputs(input logic valid, input logic get);
    imem_valid    = valid;
    get_next_inst = get;
    #2;
  endtask

  task automatic expect_after_edge(input addr_t next_pc);
    @(posedge clock);
    #1;
    check_value("imem_addr", imem_addr, block_addr(next_pc));
    exp_pc = next_pc;
  endtask

  // one-cycle update strobe
  task automatic train(input addr_t pc, input logic taken, input addr_t dest);
    update_valid  = 1'b1;
    update_pc     = pc;
    update_taken  = taken;
    update_target = dest;
    @(posedge clock);
    #1;
    update_valid  = 1'b0;
  endtask

  ////////////////////
  // watchdog and assertion monitor
  ////////////////////

  initial
  begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the stimulus finished");
  end

  always @(negedge clock)
  begin
    if (dut.fetch_checks.error_count != 0)
      fail_run("a fetch assertion failed");
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    logic valid;
    logic get;
    int   steps;
    reset         = 1'b1;
    get_next_inst = 1'b0;
    imem_valid    = 1'b0;
    update_valid  = 1'b0;
    update_pc     = '0;
    update_taken  = 1'b0;
    update_target = '0;
    lfsr_state    = 32'hb834;
    exp_pc        = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;

    // install both branches while memory is idle
    train(BRANCH_A_PC, 1'b1, BRANCH_A_DEST);
    train(BRANCH_B_PC, 1'b1, BRANCH_B_DEST);
    apply_inputs(1'b0, 1'b0);
    check_value("imem_addr", imem_addr, 64'h0);
    expect_after_edge(exp_pc);

    // random stalls that stay below the trained addresses
    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      random_level(valid);
      random_level(get);
      apply_inputs(valid, get);
      expect_after_edge((valid && get) ? seq_pc(exp_pc) : exp_pc);
    end

    // walk up to the slot 0 branch
    steps = int'((BRANCH_A_PC - exp_pc) >> 3);
    repeat (steps)
    begin
      apply_inputs(1'b1, 1'b1);
      expect_after_edge(seq_pc(exp_pc));
    end

    // slot 0 branch taken with get_next_inst low
    apply_inputs(1'b1, 1'b0);
    check_value("target[0]", target[0], BRANCH_A_DEST);
    expect_after_edge(BRANCH_A_DEST);

    // upper word with only slot 1 fetched
    apply_inputs(1'b1, 1'b1);
    check_value("npc[1]", npc[1], BRANCH_A_DEST + 64'd4);
    expect_after_edge(BRANCH_A_DEST + 64'd4);

    // slot 1 branch while slot 0 falls through
    apply_inputs(1'b1, 1'b1);
    check_value("target[0]", target[0], BRANCH_B_PC);
    check_value("target[1]", target[1], BRANCH_B_DEST);
    expect_after_edge(BRANCH_B_DEST);

    // back-pressure holds the pc
    apply_inputs(1'b0, 1'b1);
    expect_after_edge(exp_pc);
    apply_inputs(1'b1, 1'b0);
    expect_after_edge(exp_pc);
    apply_inputs(1'b1, 1'b1);
    expect_after_edge(BRANCH_C_PC);

    // branch back and then weaken the slot 0 entry to 0
    apply_inputs(1'b0, 1'b0);
    expect_after_edge(exp_pc);
    train(BRANCH_C_PC, 1'b1, BRANCH_A_PC);
    train(BRANCH_A_PC, 1'b0, '0);
    train(BRANCH_A_PC, 1'b0, '0);
    apply_inputs(1'b1, 1'b0);
    check_value("target[0]", target[0], BRANCH_A_PC);
    expect_after_edge(BRANCH_A_PC);

    // no longer taken so the fetch is sequential with targets at npc
    apply_inputs(1'b1, 1'b1);
    check_value("target[0]", target[0], BRANCH_A_PC + 64'd4);
    check_value("target[1]", target[1], BRANCH_A_PC + 64'd8);
    expect_after_edge(BRANCH_A_PC + 64'd8);
    apply_inputs(1'b0, 1'b0);
    expect_after_edge(exp_pc);

    @(negedge clock);
    if (dut.fetch_checks.error_count == 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
      fail_run("a fetch assertion failed");
  end

endmodule

// ==== fetch_unit.f ====
src/fetch_pkg.sv
src/btb_table.sv
src/branch_predictor.sv
src/fetch_stage.sv
src/fetch_unit.sv
verif/fetch_unit_asserts.sv
verif/fetch_unit_tb.sv

// ==== Makefile ====
# verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
